/* design/epd_pkg.sv */
// Shared types, state word layout, drive and op encodings for the pixel waveform engine
package epd_pkg;

    // Grey value of one pixel, 0 is black and 15 is white
    typedef logic [3:0] pixel_t;

    // Per-pixel frame counter kept inside the state word
    typedef logic [5:0] frame_cnt_t;

    // Dynamic frame-rate cap of fast mono mode
    typedef logic [1:0] mindrv_t;

    // Global frame counter supplied with every op
    typedef logic [7:0] glob_frame_t;

    // Per-pixel state word
    // Bits 15-12 hold the mode, 00xx is manual LUT and 1000 is fast mono
    // Manual LUT uses 13-10 as source, 9-4 as counter, 3-0 as target
    // Source overlaps the low mode bits, so only 15-14 identify manual LUT
    // Fast mono uses 9-4 as counter, 3-2 as cap, 1 kept at zero
    // Fast mono bit 0 is the previous colour, 0 black and 1 white
    typedef logic [15:0] pstate_t;

    // Drive code sent to the panel, code 3 is never produced
    typedef enum logic [1:0] {
        DRIVE_NONE  = 2'd0,
        DRIVE_BLACK = 2'd1,
        DRIVE_WHITE = 2'd2
    } drive_e;

    // Global operating state of the panel controller
    typedef enum logic [1:0] {
        OP_RUN  = 2'd0,
        OP_INIT = 2'd1
    } op_state_e;

    // Mode field values
    localparam logic [1:0] MODE_MANUAL_LUT_HI = 2'b00;
    localparam logic [3:0] MODE_FAST_MONO     = 4'b1000;

    // External op commands
    localparam logic [7:0] OP_EXT_REDRAW  = 8'h01;
    localparam logic [7:0] OP_EXT_SETMODE = 8'h02;

    // Set-mode parameters
    localparam logic [7:0] SETMODE_MANUAL_LUT = 8'h00;
    localparam logic [7:0] SETMODE_FAST_MONO  = 8'h01;

    // Fast mono transition lengths in frames
    localparam frame_cnt_t FASTM_B2W_FRAMES = 6'd9;
    localparam frame_cnt_t FASTM_W2B_FRAMES = 6'd9;

    // Manual LUT with source black, idle counter, target white
    localparam pstate_t INIT_MANUAL_LUT = {MODE_MANUAL_LUT_HI, 4'd0, 6'd0, 4'd15};

    // Fast mono idle, cap cleared, previous colour white
    localparam pstate_t INIT_FAST_MONO = {MODE_FAST_MONO, 2'b00, 6'd0, 2'b00, 1'b0, 1'b1};

    // State loaded by the init frame
    localparam pstate_t DEFAULT_STATE = INIT_MANUAL_LUT;

    // Cycles from pixel strobe to drive strobe
    localparam int PIPE_LATENCY = 3;

endpackage

/* design/pixel_update_if.sv */
// Connects the pixel processor to one mode update engine, one instance per engine
interface pixel_update_if;

    // Current state word of the pixel
    epd_pkg::pstate_t    state;
    // Target value after clear selection
    epd_pkg::pixel_t     vin;
    // Waveform LUT answer for this pixel
    epd_pkg::drive_e     lut_rd;
    // Global waveform settings
    epd_pkg::frame_cnt_t csr_lutframe;
    epd_pkg::mindrv_t    csr_mindrv;
    // Redraw or forced clear requested
    logic                update_req;

    // Engine results
    epd_pkg::pstate_t    next_state;
    epd_pkg::drive_e     drive;

    modport proc (
        output state, vin, lut_rd, csr_lutframe, csr_mindrv, update_req,
        input  next_state, drive
    );

    modport engine (
        input  state, vin, lut_rd, csr_lutframe, csr_mindrv, update_req,
        output next_state, drive
    );

endinterface

/* design/pixel_state_ram.sv */
// Holds one state word per pixel, read one cycle after the address, written at the edge
module pixel_state_ram #(
    parameter int NUM_PIXELS = 8
) (
    input  logic                          clk,
    input  logic [$clog2(NUM_PIXELS)-1:0] rd_addr,
    output epd_pkg::pstate_t              rd_data,
    input  logic                          wr_en,
    input  logic [$clog2(NUM_PIXELS)-1:0] wr_addr,
    input  epd_pkg::pstate_t              wr_data
);

    // Contents stay undefined until an init frame has visited every pixel
    epd_pkg::pstate_t mem [NUM_PIXELS];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Read before write, a colliding read sees the old word
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

/* design/manual_lut_update.sv */
// Next state and drive for a pixel in manual LUT mode, evaluated every cycle
module manual_lut_update (
    pixel_update_if.engine upd
);

    // State fields
    epd_pkg::pixel_t     target;
    epd_pkg::frame_cnt_t cnt;
    epd_pkg::frame_cnt_t cnt_dec;

    assign target  = upd.state[3:0];
    assign cnt     = upd.state[9:4];
    assign cnt_dec = cnt - 6'd1;

    always_comb begin
        if (cnt != 6'd0) begin
            // Lookup running, follow the LUT
            upd.drive = upd.lut_rd;
            // Source and target frozen while counting down
            upd.next_state = {upd.state[15:10], cnt_dec, target};
        end else begin
            // Settled pixel, panel left alone this frame
            upd.drive = epd_pkg::DRIVE_NONE;
            if (upd.update_req) begin
                // Old target becomes the source of the new transition
                upd.next_state = {upd.state[15:14], target, upd.csr_lutframe, upd.vin};
            end else begin
                upd.next_state = upd.state;
            end
        end
    end

endmodule

/* design/fast_mono_update.sv */
// Next state and drive for a pixel in fast mono mode with the dynamic frame-rate cap
module fast_mono_update (
    pixel_update_if.engine upd
);

    // State fields
    epd_pkg::frame_cnt_t cnt;
    epd_pkg::mindrv_t    cap;
    logic                prev_white;

    // Black or white decision from the top bit of the target
    logic                vin_white;
    logic                changed;

    // Counter and cap updates
    epd_pkg::frame_cnt_t cnt_dec;
    epd_pkg::frame_cnt_t cnt_full;
    epd_pkg::frame_cnt_t cnt_reverse;
    epd_pkg::mindrv_t    cap_dec;

    epd_pkg::drive_e     drive_toward_vin;
    epd_pkg::drive_e     drive_toward_prev;

    assign cnt        = upd.state[9:4];
    assign cap        = upd.state[3:2];
    assign prev_white = upd.state[0];

    assign vin_white = upd.vin[3];
    assign changed   = (vin_white != prev_white);

    assign cnt_dec = cnt - 6'd1;
    assign cap_dec = (cap != 2'd0) ? (cap - 2'd1) : 2'd0;

    // Full length for a fresh transition
    assign cnt_full = vin_white ? epd_pkg::FASTM_B2W_FRAMES : epd_pkg::FASTM_W2B_FRAMES;

    // Reversal mid-transition only needs to undo the frames already driven
    assign cnt_reverse = vin_white ? (epd_pkg::FASTM_B2W_FRAMES + 6'd1 - cnt)
                                   : (epd_pkg::FASTM_W2B_FRAMES + 6'd1 - cnt);

    assign drive_toward_vin  = vin_white ? epd_pkg::DRIVE_WHITE : epd_pkg::DRIVE_BLACK;
    assign drive_toward_prev = prev_white ? epd_pkg::DRIVE_WHITE : epd_pkg::DRIVE_BLACK;

    always_comb begin
        if (cnt != 6'd0) begin
            if (changed && (cap == 2'd0)) begin
                // Cap expired, reverse toward the new colour
                upd.drive      = drive_toward_vin;
                upd.next_state = {upd.state[15:10], cnt_reverse, upd.csr_mindrv,
                                  1'b0, vin_white};
            end else begin
                // Keep finishing the running transition
                upd.drive      = drive_toward_prev;
                upd.next_state = {upd.state[15:10], cnt_dec, cap_dec, upd.state[1:0]};
            end
        end else if (changed) begin
            // Idle pixel starts a new transition
            upd.drive      = drive_toward_vin;
            upd.next_state = {upd.state[15:10], cnt_full, upd.csr_mindrv, 1'b0, vin_white};
        end else begin
            // Idle and already at the right colour
            upd.drive      = epd_pkg::DRIVE_NONE;
            upd.next_state = upd.state;
        end
    end

endmodule

/* design/pixel_processor.sv */
// Combinational processing of one pixel, picks the mode engine and applies op overrides
module pixel_processor (
    input  epd_pkg::pstate_t     state,
    input  epd_pkg::pixel_t      pixel_in,
    input  epd_pkg::drive_e      lut_rd,
    input  epd_pkg::op_state_e   op_state,
    input  logic                 op_valid,
    input  logic [7:0]           op_cmd,
    input  logic [7:0]           op_param,
    input  epd_pkg::glob_frame_t op_framecnt,
    input  epd_pkg::frame_cnt_t  csr_lutframe,
    input  epd_pkg::mindrv_t     csr_mindrv,
    output epd_pkg::pstate_t     next_state,
    output epd_pkg::drive_e      drive
);

    // Mode decode
    logic            is_manual;

    // Op decode
    logic            redraw;
    logic            setmode;
    logic            force_clear;
    logic            setmode_apply;

    // Target value selection
    epd_pkg::pixel_t clear_colour;
    epd_pkg::pixel_t vin;

    pixel_update_if lut_if ();
    pixel_update_if mono_if ();

    // Only the upper two bits mark manual LUT
    // Mode 1000 and every unknown mode run as fast mono
    assign is_manual = (state[15:14] == epd_pkg::MODE_MANUAL_LUT_HI);

    assign redraw  = op_valid && (op_cmd == epd_pkg::OP_EXT_REDRAW);
    assign setmode = op_valid && (op_cmd == epd_pkg::OP_EXT_SETMODE);

    // Set-mode outside frame 0 degrades to a clear
    assign force_clear   = redraw || (setmode && (op_framecnt != 8'd0));
    assign setmode_apply = setmode && (op_framecnt == 8'd0);

    // Clear colour alternates over the global frame in fast mono
    always_comb begin
        if (is_manual) begin
            clear_colour = 4'hF;
        end else if ((op_framecnt[4:3] == 2'b11) || op_framecnt[5]) begin
            clear_colour = 4'h0;
        end else begin
            clear_colour = 4'hF;
        end
    end

    assign vin = force_clear ? clear_colour : pixel_in;

    // Both engines see the same inputs
    assign lut_if.state         = state;
    assign lut_if.vin           = vin;
    assign lut_if.lut_rd        = lut_rd;
    assign lut_if.csr_lutframe  = csr_lutframe;
    assign lut_if.csr_mindrv    = csr_mindrv;
    // A redraw is itself a forced clear
    assign lut_if.update_req    = force_clear;

    assign mono_if.state        = state;
    assign mono_if.vin          = vin;
    assign mono_if.lut_rd       = lut_rd;
    assign mono_if.csr_lutframe = csr_lutframe;
    assign mono_if.csr_mindrv   = csr_mindrv;
    assign mono_if.update_req   = force_clear;

    manual_lut_update lut_upd0 (
        .upd (lut_if.engine)
    );

    fast_mono_update mono_upd0 (
        .upd (mono_if.engine)
    );

    always_comb begin
        // Engine result of the active mode
        next_state = is_manual ? lut_if.next_state : mono_if.next_state;
        drive      = is_manual ? lut_if.drive : mono_if.drive;

        // Mode change replaces the state
        if (setmode_apply) begin
            case (op_param)
                epd_pkg::SETMODE_MANUAL_LUT: next_state = epd_pkg::INIT_MANUAL_LUT;
                epd_pkg::SETMODE_FAST_MONO:  next_state = epd_pkg::INIT_FAST_MONO;
                // Unknown parameters fall back to manual LUT
                default:                     next_state = epd_pkg::INIT_MANUAL_LUT;
            endcase
        end

        // Init frame wins over everything
        if (op_state == epd_pkg::OP_INIT) begin
            next_state = epd_pkg::DEFAULT_STATE;
            // x111xxx idle, 1xxxxxx black, 0xxxxxx white
            if (op_framecnt[5:3] == 3'b111) begin
                drive = epd_pkg::DRIVE_NONE;
            end else if (op_framecnt[6]) begin
                drive = epd_pkg::DRIVE_BLACK;
            end else begin
                drive = epd_pkg::DRIVE_WHITE;
            end
        end
    end

endmodule

/* design/epd_pixel_engine.sv */
// Top level of the pixel waveform engine, takes one pixel per clock, drive out three clocks later
module epd_pixel_engine #(
    parameter int NUM_PIXELS = 8
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          pixel_valid,
    input  logic [$clog2(NUM_PIXELS)-1:0] pixel_addr,
    input  epd_pkg::pixel_t               pixel_in,
    input  epd_pkg::op_state_e            op_state,
    input  logic                          op_valid,
    input  logic [7:0]                    op_cmd,
    input  logic [7:0]                    op_param,
    input  epd_pkg::glob_frame_t          op_framecnt,
    input  epd_pkg::frame_cnt_t           csr_lutframe,
    input  epd_pkg::mindrv_t              csr_mindrv,
    input  epd_pkg::drive_e               lut_rd,
    output epd_pkg::pixel_t               lut_src,
    output epd_pkg::pixel_t               lut_dst,
    output epd_pkg::frame_cnt_t           lut_frame,
    output logic                          drive_valid,
    output epd_pkg::drive_e               drive
);

    // Stage valids
    logic                          s1_valid;
    logic                          s2_valid;

    // Stage 1 payload, waiting for the state read
    logic [$clog2(NUM_PIXELS)-1:0] s1_addr;
    epd_pkg::pixel_t               s1_pixel;
    epd_pkg::op_state_e            s1_op_state;
    logic                          s1_op_valid;
    logic [7:0]                    s1_op_cmd;
    logic [7:0]                    s1_op_param;
    epd_pkg::glob_frame_t          s1_op_framecnt;
    epd_pkg::frame_cnt_t           s1_lutframe;
    epd_pkg::mindrv_t              s1_mindrv;

    // Stage 2 payload, waiting for the LUT answer
    logic [$clog2(NUM_PIXELS)-1:0] s2_addr;
    epd_pkg::pstate_t              s2_state;
    epd_pkg::pixel_t               s2_pixel;
    epd_pkg::op_state_e            s2_op_state;
    logic                          s2_op_valid;
    logic [7:0]                    s2_op_cmd;
    logic [7:0]                    s2_op_param;
    epd_pkg::glob_frame_t          s2_op_framecnt;
    epd_pkg::frame_cnt_t           s2_lutframe;
    epd_pkg::mindrv_t              s2_mindrv;

    // State memory and processor results
    epd_pkg::pstate_t              rd_state;
    epd_pkg::pstate_t              next_state;
    epd_pkg::drive_e               proc_drive;

    // Stage 0 presents the address straight to the memory
    pixel_state_ram #(
        .NUM_PIXELS (NUM_PIXELS)
    ) ram0 (
        .clk     (clk),
        .rd_addr (pixel_addr),
        .rd_data (rd_state),
        .wr_en   (s2_valid),
        .wr_addr (s2_addr),
        .wr_data (next_state)
    );

    // Stage 1 looks up the waveform for the state just read
    assign lut_src   = rd_state[13:10];
    assign lut_dst   = rd_state[3:0];
    assign lut_frame = rd_state[9:4];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid    <= 1'b0;
            s2_valid    <= 1'b0;
            drive_valid <= 1'b0;
            drive       <= epd_pkg::DRIVE_NONE;
        end else begin
            s1_valid    <= pixel_valid;
            s2_valid    <= s1_valid;
            drive_valid <= s2_valid;
            // Drive code held at no-op between strobes
            drive       <= s2_valid ? proc_drive : epd_pkg::DRIVE_NONE;
        end
    end

    // Globals are captured with the pixel so every pixel keeps its own op
    always_ff @(posedge clk) begin
        s1_addr        <= pixel_addr;
        s1_pixel       <= pixel_in;
        s1_op_state    <= op_state;
        s1_op_valid    <= op_valid;
        s1_op_cmd      <= op_cmd;
        s1_op_param    <= op_param;
        s1_op_framecnt <= op_framecnt;
        s1_lutframe    <= csr_lutframe;
        s1_mindrv      <= csr_mindrv;
    end

    always_ff @(posedge clk) begin
        s2_addr        <= s1_addr;
        s2_state       <= rd_state;
        s2_pixel       <= s1_pixel;
        s2_op_state    <= s1_op_state;
        s2_op_valid    <= s1_op_valid;
        s2_op_cmd      <= s1_op_cmd;
        s2_op_param    <= s1_op_param;
        s2_op_framecnt <= s1_op_framecnt;
        s2_lutframe    <= s1_lutframe;
        s2_mindrv      <= s1_mindrv;
    end

    // Stage 2 combines state and LUT answer, result written back at the edge
    pixel_processor proc0 (
        .state        (s2_state),
        .pixel_in     (s2_pixel),
        .lut_rd       (lut_rd),
        .op_state     (s2_op_state),
        .op_valid     (s2_op_valid),
        .op_cmd       (s2_op_cmd),
        .op_param     (s2_op_param),
        .op_framecnt  (s2_op_framecnt),
        .csr_lutframe (s2_lutframe),
        .csr_mindrv   (s2_mindrv),
        .next_state   (next_state),
        .drive        (proc_drive)
    );

endmodule

/* sim/epd_pixel_engine_checker.sv */
// Concurrent port checks that are bound into every instance of the pixel waveform engine
module epd_pixel_engine_checker #(
    parameter int ADDR_W = 3
) (
    input logic              clk,
    input logic              rst_n,
    input logic              pixel_valid,
    input logic [ADDR_W-1:0] pixel_addr,
    input logic              drive_valid,
    input logic [1:0]        drive
);

    timeunit 1ns;
    timeprecision 1ps;

    // Failed assertions so far
    int unsigned fail_count = 0;

    // Synchronous reset leaves no strobe behind
    reset_clears_valid: assert property (@(posedge clk) !rst_n |=> !drive_valid)
        else begin
            fail_count++;
            $error("drive_valid high right after a reset cycle");
        end

    // Fixed three-stage latency in both directions
    strobe_latency: assert property (@(posedge clk) disable iff (!rst_n)
        pixel_valid |-> ##(epd_pkg::PIPE_LATENCY) drive_valid)
        else begin
            fail_count++;
            $error("pixel strobe not followed by drive_valid three cycles later");
        end

    no_stray_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        drive_valid |-> $past(pixel_valid, epd_pkg::PIPE_LATENCY))
        else begin
            fail_count++;
            $error("drive_valid without a pixel strobe three cycles earlier");
        end

    // Code 3 is not a legal drive
    legal_drive: assert property (@(posedge clk) disable iff (!rst_n)
        drive_valid |-> (drive != 2'd3))
        else begin
            fail_count++;
            $error("drive code 3 presented");
        end

    // Write-back lands two cycles after issue so a pixel must wait three
    addr_spacing: assert property (@(posedge clk) disable iff (!rst_n)
        pixel_valid |-> !($past(pixel_valid, 1) && ($past(pixel_addr, 1) == pixel_addr))
                     && !($past(pixel_valid, 2) && ($past(pixel_addr, 2) == pixel_addr)))
        else begin
            fail_count++;
            $error("pixel address reissued within three cycles");
        end

endmodule

bind epd_pixel_engine epd_pixel_engine_checker #(
    .ADDR_W ($clog2(NUM_PIXELS))
) chk0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .pixel_valid (pixel_valid),
    .pixel_addr  (pixel_addr),
    .drive_valid (drive_valid),
    .drive       (drive)
);

/* sim/tb_epd_pixel_engine.sv */
// Testbench for the pixel waveform engine that replays the pattern file and checks every drive
module tb_epd_pixel_engine;

    timeunit 1ns;
    timeprecision 1ps;

    // One pattern row per cycle with eleven hex columns
    localparam int NUM_LINES  = 44;
    localparam int NUM_COLS   = 11;
    // Longest gap tolerated between two drive strobes
    localparam int WAIT_LIMIT = 20;

    logic                 clk;
    logic                 rst_n;
    logic                 pixel_valid;
    logic [2:0]           pixel_addr;
    epd_pkg::pixel_t      pixel_in;
    epd_pkg::op_state_e   op_state;
    logic                 op_valid;
    logic [7:0]           op_cmd;
    logic [7:0]           op_param;
    epd_pkg::glob_frame_t op_framecnt;
    epd_pkg::frame_cnt_t  csr_lutframe;
    epd_pkg::mindrv_t     csr_mindrv;
    epd_pkg::drive_e      lut_rd;
    epd_pkg::pixel_t      lut_src;
    epd_pkg::pixel_t      lut_dst;
    epd_pkg::frame_cnt_t  lut_frame;
    logic                 drive_valid;
    epd_pkg::drive_e      drive;

    logic [7:0]           patterns [NUM_LINES*NUM_COLS];
    logic [1:0]           expected_q [$];
    int                   num_pixels;

    epd_pixel_engine #(
        .NUM_PIXELS (8)
    ) dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .pixel_valid  (pixel_valid),
        .pixel_addr   (pixel_addr),
        .pixel_in     (pixel_in),
        .op_state     (op_state),
        .op_valid     (op_valid),
        .op_cmd       (op_cmd),
        .op_param     (op_param),
        .op_framecnt  (op_framecnt),
        .csr_lutframe (csr_lutframe),
        .csr_mindrv   (csr_mindrv),
        .lut_rd       (lut_rd),
        .lut_src      (lut_src),
        .lut_dst      (lut_dst),
        .lut_frame    (lut_frame),
        .drive_valid  (drive_valid),
        .drive        (drive)
    );

    always #20 clk = ~clk;

    // Odd frames push toward the destination colour and even frames rest
    function automatic epd_pkg::drive_e lut_lookup(input epd_pkg::pixel_t src,
                                                   input epd_pkg::pixel_t dst,
                                                   input epd_pkg::frame_cnt_t frame);
        epd_pkg::drive_e result;
        if ($isunknown({src, dst, frame})) begin
            // An unwritten state word addresses nothing and gets no valid answer
            result = epd_pkg::drive_e'(2'bxx);
        end else if (!frame[0]) begin
            result = epd_pkg::DRIVE_NONE;
        end else if (dst[3]) begin
            result = epd_pkg::DRIVE_WHITE;
        end else begin
            result = epd_pkg::DRIVE_BLACK;
        end
        return result;
    endfunction

    // External LUT answers one cycle after its address like a synchronous ROM
    always @(posedge clk) begin
        lut_rd <= lut_lookup(lut_src, lut_dst, lut_frame);
    end

    // A failed port assertion ends the run at the next falling edge
    always @(negedge clk) begin
        if (dut0.chk0.fail_count != 0) begin
            abort_run("port checker assertion failed");
        end
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1, "run aborted");
    endtask

    task automatic check_value(input logic [7:0] actual, input logic [7:0] expected,
                               input string what);
        if (actual !== expected) begin
            abort_run($sformatf("error at %0d ns: %s expected %0d got %0d",
                                $time, what, expected, actual));
        end
    endtask

    // Drives one row per rising edge and queues its expected drive
    task automatic apply_patterns();
        int base;
        for (int i = 0; i < NUM_LINES; i++) begin
            base = i * NUM_COLS;
            @(posedge clk);
            op_state     <= epd_pkg::op_state_e'(patterns[base][1:0]);
            op_valid     <= patterns[base + 1][0];
            op_cmd       <= patterns[base + 2];
            op_param     <= patterns[base + 3];
            op_framecnt  <= patterns[base + 4];
            csr_lutframe <= patterns[base + 5][5:0];
            csr_mindrv   <= patterns[base + 6][1:0];
            pixel_valid  <= patterns[base + 7][0];
            pixel_addr   <= patterns[base + 8][2:0];
            pixel_in     <= patterns[base + 9][3:0];
            if (patterns[base + 7][0]) begin
                expected_q.push_back(patterns[base + 10][1:0]);
            end
        end
        @(posedge clk);
        pixel_valid <= 1'b0;
        op_valid    <= 1'b0;
        op_state    <= epd_pkg::OP_RUN;
    endtask

    // Samples at the falling edge away from the DUT's register updates
    task automatic check_drives();
        int         waited;
        logic [1:0] expected;
        for (int n = 0; n < num_pixels; n++) begin
            waited = 0;
            @(negedge clk);
            while ((drive_valid !== 1'b1) && (waited <= WAIT_LIMIT)) begin
                waited++;
                @(negedge clk);
            end
            if (drive_valid !== 1'b1) begin
                abort_run($sformatf("timeout waiting for drive_valid of pixel %0d", n));
            end else if (expected_q.size() == 0) begin
                abort_run("drive_valid rose with no pixel in flight");
            end else begin
                expected = expected_q.pop_front();
                check_value(drive, expected, $sformatf("drive of pixel %0d", n));
            end
        end
    endtask

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        pixel_valid  = 1'b0;
        pixel_addr   = '0;
        pixel_in     = '0;
        op_state     = epd_pkg::OP_RUN;
        op_valid     = 1'b0;
        op_cmd       = '0;
        op_param     = '0;
        op_framecnt  = '0;
        csr_lutframe = '0;
        csr_mindrv   = '0;
        lut_rd       = epd_pkg::DRIVE_NONE;
        num_pixels   = 0;
        $readmemh("sim/epd_pixel_patterns.txt", patterns);
        if ($isunknown(patterns[NUM_LINES*NUM_COLS-1])) begin
            abort_run("pattern file missing or shorter than expected");
        end
        for (int i = 0; i < NUM_LINES; i++) begin
            if (patterns[i*NUM_COLS + 7][0]) begin
                num_pixels++;
            end
        end
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        fork
            apply_patterns();
            check_drives();
        join
        // The last pixel's latency assertions complete one edge after its drive
        @(negedge clk);
        if (dut0.chk0.fail_count == 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            $display("Test failed");
            $fatal(1, "port checker assertion failed");
        end
    end

endmodule

/* files.f */
design/epd_pkg.sv
design/pixel_update_if.sv
design/pixel_state_ram.sv
design/manual_lut_update.sv
design/fast_mono_update.sv
design/pixel_processor.sv
design/epd_pixel_engine.sv
sim/epd_pixel_engine_checker.sv
sim/tb_epd_pixel_engine.sv

/* Bender.yml */
package:
  name: epd_pixel_engine

sources:
  - files:
      - design/epd_pkg.sv
      - design/pixel_update_if.sv
      - design/pixel_state_ram.sv
      - design/manual_lut_update.sv
      - design/fast_mono_update.sv
      - design/pixel_processor.sv
      - design/epd_pixel_engine.sv
  - target: simulation
    files:
      - sim/epd_pixel_engine_checker.sv
      - sim/tb_epd_pixel_engine.sv

/* sim/epd_pixel_patterns.txt */
// Columns: op_state op_valid op_cmd op_param op_framecnt csr_lutframe csr_mindrv
// then pixel_valid pixel_addr pixel_in expected_drive, all hex, one row per cycle
// Init frame, framecnt 38 none, 46 black, 28 white
1 0 00 00 38 00 0 1 0 0 0
1 0 00 00 46 00 0 1 1 0 1
1 0 00 00 28 00 0 1 2 0 2
1 0 00 00 38 00 0 1 3 0 0
1 0 00 00 46 00 0 1 4 0 1
1 0 00 00 28 00 0 1 5 0 2
1 0 00 00 38 00 0 1 6 0 0
1 0 00 00 46 00 0 1 7 0 1
// Redraw on 0 with three LUT frames, set-mode fast mono on 3 and 4
0 1 01 00 01 03 0 1 0 0 0
0 1 02 01 00 00 0 1 3 0 0
0 1 02 01 00 00 0 1 4 0 0
// Pixel 0 follows the LUT, 3 and 4 go black, 4 with cap 2
0 0 00 00 00 00 0 1 0 0 2
0 0 00 00 00 00 0 1 3 0 1
0 0 00 00 00 00 2 1 4 0 1
// Pixel 4 reverses inside the cap window
0 0 00 00 00 00 0 1 0 0 0
0 0 00 00 00 00 0 1 3 0 1
0 0 00 00 00 00 0 1 4 f 1
0 0 00 00 00 00 0 1 0 0 2
0 0 00 00 00 00 0 1 3 0 1
0 0 00 00 00 00 0 1 4 f 1
// Cap spent, pixel 4 turns white with three frames left
0 0 00 00 00 00 0 1 0 0 0
0 0 00 00 00 00 0 1 3 0 1
0 0 00 00 00 00 0 1 4 f 2
// Pixel 5 to fast mono, redraw clears it to black, late set-mode clears to white
0 1 02 01 00 00 0 1 5 0 0
0 0 00 00 00 00 0 1 3 0 1
0 0 00 00 00 00 0 1 4 f 2
0 1 01 00 20 00 0 1 5 f 1
0 0 00 00 00 00 0 1 3 0 1
0 0 00 00 00 00 0 1 4 f 2
0 1 02 00 08 00 0 1 5 f 2
0 0 00 00 00 00 0 1 3 0 1
0 0 00 00 00 00 0 1 4 f 2
// Pixel 5 still fast mono, finishing its one frame
0 0 00 00 00 00 0 1 5 f 2
0 0 00 00 00 00 0 1 3 0 1
0 0 00 00 00 00 0 1 4 f 0
0 0 00 00 00 00 0 1 5 f 0
0 0 00 00 00 00 0 1 3 0 1
0 0 00 00 00 00 0 1 4 f 0
0 0 00 00 00 00 0 1 5 f 0
0 0 00 00 00 00 0 1 3 0 1
0 0 00 00 00 00 0 1 4 f 0
// Pixel 3 settles after ten black frames
0 0 00 00 00 00 0 1 5 f 0
0 0 00 00 00 00 0 1 3 0 0
0 0 00 00 00 00 0 1 4 f 0
